// File: rtl/gb_io_pkg.sv
`default_nettype none

package gb_io_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes and counts
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_PADS    = 4;
    localparam int SYNC_STAGES = 3;
    localparam int HS_DELAY    = 7;

    // settings register offsets
    localparam logic [11:0] ADDR_RESET  = 12'h050;
    localparam logic [11:0] ADDR_FF_EN  = 12'h20C;
    localparam logic [11:0] ADDR_FF_SND = 12'h210;

    // soft reset hold, in clk_sys cycles
    localparam int unsigned RESET_HOLD_DEFAULT = 32'h0010_0000;
    // 0.2 s at 16 MHz
    localparam int unsigned FF_TAP_DEFAULT = 3_200_000;

    ////////////////////////////////////////////////////////////////////////////
    // bus types
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [11:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // controller key bitmap, dpad_up is bit 0
    typedef struct packed {
        logic [3:0]  pad_type;
        logic [11:0] reserved;
        logic        face_start;
        logic        face_select;
        logic        trig_r3;
        logic        trig_l3;
        logic        trig_r2;
        logic        trig_l2;
        logic        trig_r1;
        logic        trig_l1;
        logic        face_y;
        logic        face_x;
        logic        face_b;
        logic        face_a;
        logic        dpad_right;
        logic        dpad_left;
        logic        dpad_down;
        logic        dpad_up;
    } pad_key_t;

    // console button byte, active high
    typedef struct packed {
        logic start;
        logic select;
        logic b;
        logic a;
        logic down;
        logic up;
        logic left;
        logic right;
    } joy_byte_t;

    typedef struct packed {
        logic ff_en;
        logic ff_snd_en;
    } settings_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } audio_t;

endpackage

`default_nettype wire

// File: rtl/apb_settings.sv
`default_nettype none

module apb_settings #(
    parameter int unsigned RESET_HOLD_CYCLES = gb_io_pkg::RESET_HOLD_DEFAULT
) (
    input  wire                   clk_sys,
    input  wire                   rst,
    input  wire gb_io_pkg::apb_req_t apb_req,
    output gb_io_pkg::apb_rsp_t   apb_rsp,
    output gb_io_pkg::settings_t  settings,
    output logic                  core_reset
);

    localparam int HOLD_W = (RESET_HOLD_CYCLES > 1) ? $clog2(RESET_HOLD_CYCLES + 1) : 1;

    logic              access;
    logic              wr_en;
    logic              hit_reset;
    logic              hit_ff_en;
    logic              hit_ff_snd;
    logic              hold_busy;
    logic [HOLD_W-1:0] hold_cnt;
    logic [31:0]       rdata;

    // zero wait state slave, access phase is psel & penable
    assign access = apb_req.psel & apb_req.penable;
    assign wr_en  = access & apb_req.pwrite;

    assign hit_reset  = (apb_req.paddr == gb_io_pkg::ADDR_RESET);
    assign hit_ff_en  = (apb_req.paddr == gb_io_pkg::ADDR_FF_EN);
    assign hit_ff_snd = (apb_req.paddr == gb_io_pkg::ADDR_FF_SND);

    ////////////////////////////////////////////////////////////////////////////
    // enable bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            settings <= '0;
        end else if (wr_en) begin
            if (hit_ff_en) begin
                settings.ff_en <= apb_req.pwdata[0];
            end
            if (hit_ff_snd) begin
                settings.ff_snd_en <= apb_req.pwdata[0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // soft reset hold
    ////////////////////////////////////////////////////////////////////////////

    // any write to the reset register reloads the full hold
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hold_cnt <= '0;
        end else if (wr_en && hit_reset) begin
            hold_cnt <= HOLD_W'(RESET_HOLD_CYCLES);
        end else if (hold_busy) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    assign hold_busy  = (hold_cnt != '0);
    assign core_reset = rst | hold_busy;

    // read back
    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            gb_io_pkg::ADDR_RESET:  rdata[0] = hold_busy;
            gb_io_pkg::ADDR_FF_EN:  rdata[0] = settings.ff_en;
            gb_io_pkg::ADDR_FF_SND: rdata[0] = settings.ff_snd_en;
            default:                rdata    = '0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & ~(hit_reset | hit_ff_en | hit_ff_snd);

endmodule

`default_nettype wire

// File: rtl/pad_channel.sv
`default_nettype none

module pad_channel (
    input  wire                   clk_sys,
    input  wire                   rst,
    input  wire gb_io_pkg::pad_key_t key_in,
    output gb_io_pkg::pad_key_t   key_sync,
    output gb_io_pkg::joy_byte_t  buttons
);

    gb_io_pkg::pad_key_t sync_q [gb_io_pkg::SYNC_STAGES];

    // key word arrives from another domain, so run it through the chain
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int i = 0; i < gb_io_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= key_in;
            for (int i = 1; i < gb_io_pkg::SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign key_sync = sync_q[gb_io_pkg::SYNC_STAGES-1];

    // remap to the console byte
    assign buttons.start  = key_sync.face_start;
    assign buttons.select = key_sync.face_select;
    assign buttons.b      = key_sync.face_b;
    assign buttons.a      = key_sync.face_a;
    assign buttons.down   = key_sync.dpad_down;
    assign buttons.up     = key_sync.dpad_up;
    assign buttons.left   = key_sync.dpad_left;
    assign buttons.right  = key_sync.dpad_right;

endmodule

`default_nettype wire

// File: rtl/joypad_mux.sv
`default_nettype none

module joypad_mux (
    input  wire                    clk_sys,
    input  wire                    rst,
    input  wire gb_io_pkg::joy_byte_t buttons [gb_io_pkg::NUM_PADS],
    input  wire [1:0]              joy_p54,
    input  wire [1:0]              joy_players,
    output logic [3:0]             joy_din
);

    localparam int IDX_W = $clog2(gb_io_pkg::NUM_PADS);

    logic [IDX_W-1:0]     player;
    logic                 p15_q;
    logic                 step;
    logic [3:0]           dir_n;
    logic [3:0]           btn_n;
    logic [3:0]           din_next;
    gb_io_pkg::joy_byte_t cur;

    assign cur = buttons[player];

    // console side is active low
    assign dir_n = ~{cur.down, cur.up, cur.left, cur.right};
    assign btn_n = ~{cur.start, cur.select, cur.b, cur.a};

    always_comb begin
        case (joy_p54)
            2'b00:   din_next = dir_n & btn_n;
            2'b10:   din_next = dir_n;
            2'b01:   din_next = btn_n;
            default: din_next = 4'hF - 4'(player);
        endcase
    end

    // next player on a P15 rise while P14 is high
    assign step = joy_p54[1] & ~p15_q & joy_p54[0];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            player  <= '0;
            p15_q   <= 1'b1;
            joy_din <= 4'hF;
        end else begin
            p15_q   <= joy_p54[1];
            joy_din <= din_next;
            if (step) begin
                // joy_players 0 keeps player 1 only
                if (player == joy_players) begin
                    player <= '0;
                end else begin
                    player <= player + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/turbo_control.sv
`default_nettype none

module turbo_control #(
    parameter int unsigned FF_TAP_CYCLES = gb_io_pkg::FF_TAP_DEFAULT
) (
    input  wire                     clk_sys,
    input  wire                     rst,
    input  wire gb_io_pkg::settings_t settings,
    input  wire gb_io_pkg::pad_key_t  pad0,
    input  wire gb_io_pkg::audio_t    core_audio,
    output gb_io_pkg::audio_t       audio_out,
    output logic                    fast_forward
);

    localparam int TAP_W = (FF_TAP_CYCLES > 1) ? $clog2(FF_TAP_CYCLES + 1) : 1;
    localparam logic [TAP_W-1:0] TAP_LIMIT = TAP_W'(FF_TAP_CYCLES);

    logic             ff_req;
    logic             ff_req_q;
    logic             ff_latch;
    logic             tap_taken;
    logic             ff_muted;
    logic [TAP_W-1:0] held_cnt;

    assign ff_req = settings.ff_en & pad0.trig_r1;

    ////////////////////////////////////////////////////////////////////////////
    // hold or tap latch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ff_req_q     <= 1'b0;
            ff_latch     <= 1'b0;
            tap_taken    <= 1'b0;
            held_cnt     <= '0;
            fast_forward <= 1'b0;
        end else begin
            ff_req_q <= ff_req;

            // press drops any latched tap and restarts the count
            if (ff_req && !ff_req_q) begin
                ff_latch <= 1'b0;
                held_cnt <= '0;
            end else if (ff_req && held_cnt != TAP_LIMIT) begin
                held_cnt <= held_cnt + 1'b1;
            end

            // short release latches, unless this press only undid a tap
            if (!ff_req && ff_req_q) begin
                tap_taken <= 1'b0;
                if (held_cnt < TAP_LIMIT && !tap_taken) begin
                    tap_taken <= 1'b1;
                    ff_latch  <= 1'b1;
                end
            end

            fast_forward <= ff_req | ff_latch;
        end
    end

    // silence during fast forward unless asked for
    assign ff_muted  = fast_forward & ~settings.ff_snd_en;
    assign audio_out = ff_muted ? '0 : core_audio;

endmodule

`default_nettype wire

// File: rtl/video_out.sv
`default_nettype none

module video_out (
    input  wire                  clk_sys,
    input  wire                  rst,
    input  wire gb_io_pkg::rgb_t core_rgb,
    input  wire                  core_hs,
    input  wire                  core_vs,
    input  wire                  core_hblank,
    input  wire                  core_vblank,
    input  wire                  grayscale_en,
    output gb_io_pkg::rgb_t      video_rgb,
    output logic                 video_de,
    output logic                 video_hs,
    output logic                 video_vs
);

    localparam int HS_W = $clog2(gb_io_pkg::HS_DELAY + 1);

    logic            de;
    logic            hs_prev;
    logic            vs_prev;
    logic [HS_W-1:0] hs_cnt;
    logic [7:0]      lum;
    gb_io_pkg::rgb_t pix_q;

    assign de = ~(core_hblank | core_vblank);

    // pixel is blacked out outside the active area
    always_ff @(posedge clk_sys) begin
        pix_q <= de ? core_rgb : '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sync shaping
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video_de <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_cnt   <= '0;
        end else begin
            video_de <= de;
            hs_prev  <= core_hs;
            vs_prev  <= core_vs;

            // single cycle vsync on the core's rising edge
            video_vs <= core_vs & ~vs_prev;

            // hsync is pushed back so it never lands on the vsync pulse
            video_hs <= (hs_cnt == HS_W'(1));
            if (core_hs && !hs_prev) begin
                hs_cnt <= HS_W'(gb_io_pkg::HS_DELAY);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
        end
    end

    // luma weights approximate 0.28 r, 0.56 g, 0.09 b
    assign lum = (pix_q.r >> 2) + (pix_q.r >> 5)
               + (pix_q.g >> 1) + (pix_q.g >> 4)
               + (pix_q.b >> 4) + (pix_q.b >> 5);

    assign video_rgb = grayscale_en ? {lum, lum, lum} : pix_q;

endmodule

`default_nettype wire

// File: rtl/gb_io_top.sv
`default_nettype none

module gb_io_top #(
    parameter int unsigned RESET_HOLD_CYCLES = gb_io_pkg::RESET_HOLD_DEFAULT,
    parameter int unsigned FF_TAP_CYCLES     = gb_io_pkg::FF_TAP_DEFAULT
) (
    input  wire                      clk_sys,
    input  wire                      rst,
    input  wire gb_io_pkg::apb_req_t apb_req,
    output gb_io_pkg::apb_rsp_t      apb_rsp,
    input  wire gb_io_pkg::pad_key_t pad_keys [gb_io_pkg::NUM_PADS],
    input  wire [1:0]                joy_p54,
    input  wire [1:0]                joy_players,
    output logic [3:0]               joy_din,
    input  wire gb_io_pkg::audio_t   core_audio,
    output gb_io_pkg::audio_t        audio_out,
    output logic                     fast_forward,
    output logic                     core_reset,
    input  wire gb_io_pkg::rgb_t     core_rgb,
    input  wire                      core_hs,
    input  wire                      core_vs,
    input  wire                      core_hblank,
    input  wire                      core_vblank,
    input  wire                      grayscale_en,
    output gb_io_pkg::rgb_t          video_rgb,
    output logic                     video_de,
    output logic                     video_hs,
    output logic                     video_vs
);

    gb_io_pkg::settings_t settings;
    gb_io_pkg::pad_key_t  key_sync  [gb_io_pkg::NUM_PADS];
    gb_io_pkg::joy_byte_t joy_bytes [gb_io_pkg::NUM_PADS];

    apb_settings #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) u_settings (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .settings   (settings),
        .core_reset (core_reset)
    );

    ////////////////////////////////////////////////////////////////////////////
    // controllers
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < gb_io_pkg::NUM_PADS; i++) begin : g_pad
        pad_channel u_pad (
            .clk_sys  (clk_sys),
            .rst      (rst),
            .key_in   (pad_keys[i]),
            .key_sync (key_sync[i]),
            .buttons  (joy_bytes[i])
        );
    end

    joypad_mux u_joy (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .buttons     (joy_bytes),
        .joy_p54     (joy_p54),
        .joy_players (joy_players),
        .joy_din     (joy_din)
    );

    // player 1 owns the fast forward trigger
    turbo_control #(
        .FF_TAP_CYCLES (FF_TAP_CYCLES)
    ) u_turbo (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .settings     (settings),
        .pad0         (key_sync[0]),
        .core_audio   (core_audio),
        .audio_out    (audio_out),
        .fast_forward (fast_forward)
    );

    video_out u_video (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .core_rgb     (core_rgb),
        .core_hs      (core_hs),
        .core_vs      (core_vs),
        .core_hblank  (core_hblank),
        .core_vblank  (core_vblank),
        .grayscale_en (grayscale_en),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs)
    );

endmodule

`default_nettype wire

// File: tests/tb_gb_io.sv
`default_nettype none

module tb_gb_io;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOLD = 40;
    localparam int TAP  = 30;
    localparam int LAST = gb_io_pkg::SYNC_STAGES - 1;

    logic                clk_sys;
    logic                rst;
    gb_io_pkg::apb_req_t apb_req;
    gb_io_pkg::apb_rsp_t apb_rsp;
    gb_io_pkg::pad_key_t pad_keys [gb_io_pkg::NUM_PADS];
    logic [1:0]          joy_p54;
    logic [1:0]          joy_players;
    logic [3:0]          joy_din;
    gb_io_pkg::audio_t   core_audio;
    gb_io_pkg::audio_t   audio_out;
    logic                fast_forward;
    logic                core_reset;
    gb_io_pkg::rgb_t     core_rgb;
    logic                core_hs;
    logic                core_vs;
    logic                core_hblank;
    logic                core_vblank;
    logic                grayscale_en;
    gb_io_pkg::rgb_t     video_rgb;
    logic                video_de;
    logic                video_hs;
    logic                video_vs;

    // reference state
    logic [15:0]         lfsr;
    logic                apb_access;
    logic                apb_wr;
    logic                apb_mapped;
    logic                ff_en_m;
    logic                snd_m;
    int                  hold_m;
    gb_io_pkg::pad_key_t key_pipe [gb_io_pkg::SYNC_STAGES][gb_io_pkg::NUM_PADS];
    logic [1:0]          player_m;
    logic                p15_m;
    logic [3:0]          joy_m;
    logic                req_m;
    logic                req_q;
    logic                latch_m;
    logic                tap_m;
    logic                ff_m;
    int                  held_m;
    logic                de_m;
    logic                vs_prev_m;
    logic                vs_m;
    gb_io_pkg::rgb_t     pix_m;

    gb_io_top #(
        .RESET_HOLD_CYCLES (HOLD),
        .FF_TAP_CYCLES     (TAP)
    ) u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit
    task automatic lfsr_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
    endtask

    task automatic advance_cycles(input int n);
        repeat (n) begin
            @(posedge clk_sys);
            #1;
        end
    endtask

    task automatic apb_transfer(input logic [11:0] addr, input logic wr, input logic [31:0] data);
        int cnt;
        apb_req.paddr   = addr;
        apb_req.pwrite  = wr;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        advance_cycles(1);
        apb_req.penable = 1'b1;
        cnt = 0;
        while (apb_rsp.pready !== 1'b1) begin
            advance_cycles(1);
            cnt++;
            if (cnt > 16) stop_with_failure("APB access timed out, pready stayed low");
        end
        advance_cycles(1);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        apb_transfer(addr, 1'b1, data);
    endtask

    task automatic apb_read(input logic [11:0] addr);
        apb_transfer(addr, 1'b0, 32'h0);
    endtask

    task automatic wait_fast_forward(input logic level, input string what);
        int cnt;
        cnt = 0;
        while (fast_forward !== level) begin
            advance_cycles(1);
            cnt++;
            if (cnt > 20) stop_with_failure({"timed out waiting for ", what});
        end
    endtask

    task automatic wait_core_reset_low();
        int cnt;
        cnt = 0;
        while (core_reset !== 1'b0) begin
            advance_cycles(1);
            cnt++;
            if (cnt > HOLD + 20) stop_with_failure("timed out waiting for the soft reset to end");
        end
    endtask

    // console nibble for one select value straight from the key bitmap
    function automatic logic [3:0] joy_nibble(input logic [1:0] sel,
                                              input gb_io_pkg::pad_key_t key,
                                              input logic [1:0] idx);
        logic [3:0] dir_n;
        logic [3:0] btn_n;
        dir_n = ~{key.dpad_down, key.dpad_up, key.dpad_left, key.dpad_right};
        btn_n = ~{key.face_start, key.face_select, key.face_b, key.face_a};
        case (sel)
            2'b00:   return dir_n & btn_n;
            2'b10:   return dir_n;
            2'b01:   return btn_n;
            default: return 4'hF - {2'b00, idx};
        endcase
    endfunction

    function automatic logic [7:0] luma_of(input gb_io_pkg::rgb_t p);
        logic [9:0] sum;
        sum = (p.r >> 2) + (p.r >> 5) + (p.g >> 1) + (p.g >> 4) + (p.b >> 4) + (p.b >> 5);
        return sum[7:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference models
    ////////////////////////////////////////////////////////////////////////////

    assign apb_access = apb_req.psel & apb_req.penable;
    assign apb_wr     = apb_access & apb_req.pwrite;
    assign apb_mapped = apb_req.paddr inside {gb_io_pkg::ADDR_RESET, gb_io_pkg::ADDR_FF_EN,
                                              gb_io_pkg::ADDR_FF_SND};
    assign req_m      = ff_en_m & key_pipe[LAST][0].trig_r1;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            ff_en_m <= 1'b0;
            snd_m   <= 1'b0;
            hold_m  <= 0;
        end else begin
            if (apb_wr && apb_req.paddr == gb_io_pkg::ADDR_FF_EN) ff_en_m <= apb_req.pwdata[0];
            if (apb_wr && apb_req.paddr == gb_io_pkg::ADDR_FF_SND) snd_m <= apb_req.pwdata[0];
            if (apb_wr && apb_req.paddr == gb_io_pkg::ADDR_RESET) begin
                hold_m <= HOLD;
            end else if (hold_m != 0) begin
                hold_m <= hold_m - 1;
            end
        end
    end

    // key sync, player select and the registered nibble
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            key_pipe <= '{default: '0};
            player_m <= 2'd0;
            p15_m    <= 1'b1;
            joy_m    <= 4'hF;
        end else begin
            for (int p = 0; p < gb_io_pkg::NUM_PADS; p++) begin
                key_pipe[0][p] <= pad_keys[p];
                for (int s = 1; s < gb_io_pkg::SYNC_STAGES; s++) begin
                    key_pipe[s][p] <= key_pipe[s-1][p];
                end
            end
            p15_m <= joy_p54[1];
            joy_m <= joy_nibble(joy_p54, key_pipe[LAST][player_m], player_m);
            if (joy_p54[1] && !p15_m && joy_p54[0]) begin
                player_m <= (player_m == joy_players) ? 2'd0 : player_m + 2'd1;
            end
        end
    end

    // hold or tap latch
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            req_q   <= 1'b0;
            latch_m <= 1'b0;
            tap_m   <= 1'b0;
            held_m  <= 0;
            ff_m    <= 1'b0;
        end else begin
            req_q <= req_m;
            if (req_m && !req_q) begin
                latch_m <= 1'b0;
                held_m  <= 0;
            end else if (req_m) begin
                held_m <= held_m + 1;
            end
            // a short release latches once and the press after it only clears
            if (!req_m && req_q) begin
                tap_m <= !tap_m && held_m < TAP;
                if (!tap_m && held_m < TAP) latch_m <= 1'b1;
            end
            ff_m <= req_m | latch_m;
        end
    end

    always_ff @(posedge clk_sys) begin
        pix_m <= (core_hblank || core_vblank) ? '0 : core_rgb;
        if (rst) begin
            de_m      <= 1'b0;
            vs_prev_m <= 1'b0;
            vs_m      <= 1'b0;
        end else begin
            de_m      <= !(core_hblank || core_vblank);
            vs_prev_m <= core_vs;
            vs_m      <= core_vs && !vs_prev_m;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_apb_rsp: assert property (@(posedge clk_sys) disable iff (rst)
        apb_access |-> apb_rsp.pready && (apb_rsp.pslverr == !apb_mapped))
        else stop_with_failure($sformatf("ERROR @%0t: pready/pslverr wrong for address %h",
                                         $time, $sampled(apb_req.paddr)));

    a_rd_ff_en: assert property (@(posedge clk_sys) disable iff (rst)
        apb_access && !apb_req.pwrite && apb_req.paddr == gb_io_pkg::ADDR_FF_EN
        |-> apb_rsp.prdata == {31'b0, ff_en_m})
        else stop_with_failure($sformatf("ERROR @%0t: fast-forward enable read back wrong",
                                         $time));

    a_rd_ff_snd: assert property (@(posedge clk_sys) disable iff (rst)
        apb_access && !apb_req.pwrite && apb_req.paddr == gb_io_pkg::ADDR_FF_SND
        |-> apb_rsp.prdata == {31'b0, snd_m})
        else stop_with_failure($sformatf("ERROR @%0t: fast-forward sound read back wrong",
                                         $time));

    a_rd_reset: assert property (@(posedge clk_sys) disable iff (rst)
        apb_access && !apb_req.pwrite && apb_req.paddr == gb_io_pkg::ADDR_RESET
        |-> apb_rsp.prdata == {31'b0, hold_m != 0})
        else stop_with_failure($sformatf("ERROR @%0t: soft reset status read back wrong",
                                         $time));

    a_core_reset: assert property (@(posedge clk_sys) core_reset == (rst || hold_m != 0))
        else stop_with_failure($sformatf("ERROR @%0t: core_reset is %b, hold left %0d",
                                         $time, $sampled(core_reset), $sampled(hold_m)));

    a_joy_din: assert property (@(posedge clk_sys) disable iff (rst) joy_din == joy_m)
        else stop_with_failure($sformatf("ERROR @%0t: joy_din %h, expected %h",
                                         $time, $sampled(joy_din), $sampled(joy_m)));

    a_fast_forward: assert property (@(posedge clk_sys) disable iff (rst) fast_forward == ff_m)
        else stop_with_failure($sformatf("ERROR @%0t: fast_forward %b, expected %b",
                                         $time, $sampled(fast_forward), $sampled(ff_m)));

    a_audio: assert property (@(posedge clk_sys) disable iff (rst)
        audio_out == ((ff_m && !snd_m) ? 32'h0 : 32'(core_audio)))
        else stop_with_failure($sformatf("ERROR @%0t: audio_out %h wrong", $time,
                                         $sampled(audio_out)));

    a_video_de: assert property (@(posedge clk_sys) disable iff (rst) video_de == de_m)
        else stop_with_failure($sformatf("ERROR @%0t: video_de does not follow the blanks",
                                         $time));

    a_video_rgb: assert property (@(posedge clk_sys) disable iff (rst)
        video_rgb == (grayscale_en ? {3{luma_of(pix_m)}} : pix_m))
        else stop_with_failure($sformatf("ERROR @%0t: video_rgb %h wrong", $time,
                                         $sampled(video_rgb)));

    a_video_vs: assert property (@(posedge clk_sys) disable iff (rst) video_vs == vs_m)
        else stop_with_failure($sformatf("ERROR @%0t: video_vs pulse wrong", $time));

    a_video_hs: assert property (@(posedge clk_sys) disable iff (rst)
        $rose(core_hs) |-> ##1 !video_hs [*gb_io_pkg::HS_DELAY] ##1 video_hs ##1 !video_hs)
        else stop_with_failure($sformatf("ERROR @%0t: video_hs pulse not %0d edges after hs",
                                         $time, gb_io_pkg::HS_DELAY));

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] bits;
        lfsr         = 16'd10590;
        rst          = 1'b1;
        apb_req      = '0;
        pad_keys     = '{default: '0};
        joy_p54      = 2'b11;
        joy_players  = 2'b11;
        core_audio   = 32'h1234_ABCD;
        core_rgb     = '0;
        core_hs      = 1'b0;
        core_vs      = 1'b0;
        core_hblank  = 1'b0;
        core_vblank  = 1'b0;
        grayscale_en = 1'b0;
        repeat (2) @(posedge clk_sys);
        #1;
        rst = 1'b0;
        advance_cycles(3);

        // register block
        apb_write(gb_io_pkg::ADDR_FF_EN, 32'h1);
        apb_read(gb_io_pkg::ADDR_FF_EN);
        apb_write(gb_io_pkg::ADDR_FF_SND, 32'hFFFF_FFFF);
        apb_read(gb_io_pkg::ADDR_FF_SND);
        apb_write(gb_io_pkg::ADDR_FF_SND, 32'h0);
        apb_read(gb_io_pkg::ADDR_FF_SND);
        apb_read(12'h100);
        apb_write(12'h3FC, 32'h1);
        apb_write(gb_io_pkg::ADDR_FF_EN, 32'h0);
        apb_read(gb_io_pkg::ADDR_FF_EN);

        // soft reset hold
        apb_write(gb_io_pkg::ADDR_RESET, 32'h0000_00A5);
        advance_cycles(5);
        apb_read(gb_io_pkg::ADDR_RESET);
        wait_core_reset_low();
        apb_read(gb_io_pkg::ADDR_RESET);

        // player id stepping and then random keys under every select value
        for (int i = 0; i < 10; i++) begin
            joy_p54 = 2'b01;
            advance_cycles(3);
            joy_p54 = 2'b11;
            advance_cycles(3);
        end
        for (int i = 0; i < 24; i++) begin
            for (int p = 0; p < gb_io_pkg::NUM_PADS; p++) begin
                lfsr_bits(32, bits);
                pad_keys[p] = gb_io_pkg::pad_key_t'(bits);
            end
            advance_cycles(5);
            joy_p54 = 2'b10;
            advance_cycles(3);
            joy_p54 = 2'b01;
            advance_cycles(3);
            joy_p54 = 2'b00;
            advance_cycles(3);
            joy_p54 = 2'b11;
            advance_cycles(3);
        end

        // fast forward with a hold, a tap and a second tap that only clears
        apb_write(gb_io_pkg::ADDR_FF_EN, 32'h1);
        pad_keys = '{default: '0};
        advance_cycles(6);
        lfsr_bits(32, bits);
        core_audio = bits;
        pad_keys[0].trig_r1 = 1'b1;
        wait_fast_forward(1'b1, "fast_forward to rise on an R1 hold");
        advance_cycles(50);
        pad_keys[0].trig_r1 = 1'b0;
        wait_fast_forward(1'b0, "fast_forward to drop after a long R1 hold");
        pad_keys[0].trig_r1 = 1'b1;
        advance_cycles(10);
        pad_keys[0].trig_r1 = 1'b0;
        advance_cycles(20);
        lfsr_bits(32, bits);
        core_audio = bits;
        apb_write(gb_io_pkg::ADDR_FF_SND, 32'h1);
        advance_cycles(4);
        apb_write(gb_io_pkg::ADDR_FF_SND, 32'h0);
        advance_cycles(4);
        pad_keys[0].trig_r1 = 1'b1;
        advance_cycles(10);
        pad_keys[0].trig_r1 = 1'b0;
        wait_fast_forward(1'b0, "fast_forward to drop after the press that clears the latch");
        lfsr_bits(32, bits);
        core_audio = bits;
        advance_cycles(4);

        // video with grayscale in the second half
        for (int c = 0; c < 240; c++) begin
            lfsr_bits(24, bits);
            core_rgb = gb_io_pkg::rgb_t'(bits[23:0]);
            lfsr_bits(1, bits);
            core_hblank  = bits[0];
            core_vblank  = (c % 120) < 10;
            core_hs      = (c % 40) < 4;
            core_vs      = (c % 120) >= 2 && (c % 120) < 5;
            grayscale_en = c >= 120;
            advance_cycles(1);
        end
        advance_cycles(10);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/gb_io_pkg.sv
rtl/apb_settings.sv
rtl/pad_channel.sv
rtl/joypad_mux.sv
rtl/turbo_control.sv
rtl/video_out.sv
rtl/gb_io_top.sv
tests/tb_gb_io.sv
